//--- video_consts.svh
// raster, sync, overscan and OSD constants for the video output stage
// include wherever positions or serial commands are decoded
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// raster of 256x240 in a 341x262 frame
`define H_ACTIVE 256
`define H_TOTAL 341
`define V_ACTIVE 240
`define V_TOTAL 262

`define HS_START 279
`define HS_END 304 // exclusive
`define VS_START 245
`define VS_END 248 // exclusive

// border hidden when overscan dimming is on
`define OS_LEFT 10
`define OS_RIGHT 240
`define OS_TOP 6
`define OS_BOTTOM 230

`define OSD_X 96
`define OSD_Y 112
`define OSD_W 64
`define OSD_H 16

`define CMD_WRITE 8'h20
`define CMD_ENABLE 8'h40
`define CMD_DISABLE 8'h41

`endif

//--- video_pkg.sv
// pixel and counter types shared by the video output stage
`default_nettype none

package video_pkg;

	typedef logic [5:0] color_idx_t; // palette index from the source

	// palette word, red in the low bits as in the data files
	typedef struct packed {
		logic [4:0] b;
		logic [4:0] g;
		logic [4:0] r;
	} rgb15_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} rgb18_t;

	typedef logic [8:0] hpos_t;
	typedef logic [8:0] vpos_t;

endpackage

`default_nettype wire

//--- video_timing.sv
// raster counters locked to the source frame start, with decoded flags
// and sync delayed to line up with the pixel pipeline
`timescale 1ns/10ps
`default_nettype none
`include "video_consts.svh"

module video_timing (
	input  logic             clk,
	input  logic             arst_n,
	input  video_pkg::vpos_t count_v,
	output logic             picture,
	output logic             overscan,
	output logic             odd_line,
	output logic             hs,
	output logic             vs,
	output video_pkg::hpos_t hpos,
	output video_pkg::vpos_t vpos
);
	video_pkg::hpos_t h, h_d1;
	video_pkg::vpos_t v, v_d1;
	video_pkg::vpos_t count_v_q;
	logic frame_start;
	logic h_end, v_end;
	logic hs_d1, vs_d1;

	assign frame_start = (count_v == '0) && (count_v_q != '0);
	assign h_end = (h == 9'(`H_TOTAL - 1));
	assign v_end = (v == 9'(`V_TOTAL - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			h <= '0;
			v <= '0;
			count_v_q <= '0;
		end else begin
			count_v_q <= count_v;
			if (frame_start) begin // resync to source
				h <= '0;
				v <= '0;
			end else if (h_end) begin
				h <= '0;
				v <= v_end ? '0 : v + 9'd1;
			end else begin
				h <= h + 9'd1;
			end
		end
	end

	// stage 1 matches the palette word, stage 2 the shaded pixel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			picture <= 1'b0;
			overscan <= 1'b0;
			odd_line <= 1'b0;
			h_d1 <= '0;
			v_d1 <= '0;
			hs_d1 <= 1'b0;
			vs_d1 <= 1'b0;
			hpos <= '0;
			vpos <= '0;
			hs <= 1'b0;
			vs <= 1'b0;
		end else begin
			picture <= (h < `H_ACTIVE) && (v < `V_ACTIVE);
			overscan <= (h < `OS_LEFT) || (h >= `OS_RIGHT) || (v < `OS_TOP) || (v > `OS_BOTTOM);
			odd_line <= v[0];
			h_d1 <= h;
			v_d1 <= v;
			hs_d1 <= (h >= `HS_START) && (h < `HS_END);
			vs_d1 <= (v >= `VS_START) && (v < `VS_END);
			hpos <= h_d1;
			vpos <= v_d1;
			hs <= hs_d1;
			vs <= vs_d1;
		end
	end

endmodule

`default_nettype wire

//--- nes_palette.sv
// two 64-entry RGB555 palette ROMs with a registered lookup
`timescale 1ns/10ps
`default_nettype none

module nes_palette (
	input  logic                  clk,
	input  logic                  arst_n,
	input  video_pkg::color_idx_t color,
	input  logic                  palette, // 1 selects unsaturated
	output video_pkg::rgb15_t     word
);
	// data files hold 16-bit words, top bit unused
	logic [15:0] rom_fceux [0:63];
	logic [15:0] rom_unsat [0:63];
	logic [15:0] entry;

	initial begin
		$readmemh("nes_palette_fceux.txt", rom_fceux);
		$readmemh("nes_palette_unsat.txt", rom_unsat);
	end

	assign entry = palette ? rom_unsat[color] : rom_fceux[color];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			word <= '0;
		else
			word <= video_pkg::rgb15_t'(entry[14:0]);
	end

endmodule

`default_nettype wire

//--- pixel_shader.sv
// blanking, overscan dimming and scanline halving on the palette word
// output is registered and widened to 6 bits per channel
`timescale 1ns/10ps
`default_nettype none

module pixel_shader (
	input  logic              clk,
	input  logic              arst_n,
	input  video_pkg::rgb15_t word,
	input  logic              picture,
	input  logic              overscan,
	input  logic              odd_line,
	input  logic              scanlines,
	input  logic              overscan_en,
	output video_pkg::rgb18_t pixel
);
	logic dim, dark;

	assign dim = overscan && overscan_en;
	assign dark = odd_line && scanlines;

	// one channel through the rules, first match wins
	function automatic logic [5:0] shade(input logic [4:0] ch);
		logic [4:0] res;
		if (!picture)
			res = 5'd0;
		else if (dim)
			res = {4'd0, ch[4]}; // msb only
		else if (dark)
			res = {1'b0, ch[4:1]};
		else
			res = ch;
		return {res, 1'b0};
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pixel <= '0;
		end else begin
			pixel.r <= shade(word.r);
			pixel.g <= shade(word.g);
			pixel.b <= shade(word.b);
		end
	end

endmodule

`default_nettype wire

//--- osd_overlay.sv
// serial-loaded OSD bitmap overlaid on the shaded pixel
// also registers and inverts the sync outputs
`timescale 1ns/10ps
`default_nettype none
`include "video_consts.svh"

module osd_overlay (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              sck,
	input  logic              ss,
	input  logic              sdi,
	input  video_pkg::rgb18_t pixel_in,
	input  video_pkg::hpos_t  hpos,
	input  video_pkg::vpos_t  vpos,
	input  logic              hs_in,
	input  logic              vs_in,
	output video_pkg::rgb18_t pixel_out,
	output logic              hs_n,
	output logic              vs_n,
	output logic              osd_visible
);
	logic [2:0] sck_s; // extra stage for edge detect
	logic [1:0] ss_s, sdi_s;
	logic sck_rise, rx_done;
	logic [2:0] bit_cnt;
	logic [6:0] shift;
	logic [7:0] rx_byte;
	logic have_cmd, wr_mode;
	logic [6:0] addr;
	logic [7:0] bitmap [0:127]; // 16 rows of 8 bytes
	video_pkg::hpos_t wx;
	video_pkg::vpos_t wy;
	logic in_win, osd_bit;

	assign sck_rise = sck_s[1] && !sck_s[2];
	assign rx_byte = {shift, sdi_s[1]};
	assign rx_done = !ss_s[1] && sck_rise && (bit_cnt == 3'd7);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sck_s <= '0;
			ss_s <= '1;
			sdi_s <= '0;
		end else begin
			sck_s <= {sck_s[1:0], sck};
			ss_s <= {ss_s[0], ss};
			sdi_s <= {sdi_s[0], sdi};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt <= '0;
			shift <= '0;
			have_cmd <= 1'b0;
			wr_mode <= 1'b0;
			addr <= '0;
			osd_visible <= 1'b0;
		end else if (ss_s[1]) begin // end of transfer, drop partial byte
			bit_cnt <= '0;
			have_cmd <= 1'b0;
			wr_mode <= 1'b0;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
			shift <= rx_byte[6:0];
			if (rx_done && !have_cmd) begin
				have_cmd <= 1'b1;
				wr_mode <= (rx_byte == `CMD_WRITE);
				addr <= '0;
				if (rx_byte == `CMD_ENABLE)
					osd_visible <= 1'b1;
				else if (rx_byte == `CMD_DISABLE)
					osd_visible <= 1'b0;
			end else if (rx_done && wr_mode) begin
				addr <= addr + 7'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_done && have_cmd && wr_mode)
			bitmap[addr] <= rx_byte;
	end

	// positions left of or above the window wrap to large values
	assign wx = hpos - 9'(`OSD_X);
	assign wy = vpos - 9'(`OSD_Y);
	assign in_win = (wx < `OSD_W) && (wy < `OSD_H);
	assign osd_bit = bitmap[{wy[3:0], wx[5:3]}][~wx[2:0]]; // msb leftmost

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pixel_out <= '0;
			hs_n <= 1'b1;
			vs_n <= 1'b1;
		end else begin
			hs_n <= !hs_in;
			vs_n <= !vs_in;
			if (osd_visible && in_win && osd_bit) begin
				pixel_out <= '1; // white
			end else if (osd_visible && in_win) begin
				pixel_out.r <= {1'b0, pixel_in.r[5:1]};
				pixel_out.g <= {1'b0, pixel_in.g[5:1]};
				pixel_out.b <= {1'b0, pixel_in.b[5:1]};
			end else begin
				pixel_out <= pixel_in;
			end
		end
	end

endmodule

`default_nettype wire

//--- video.sv
// video output stage top, index and line count in, 6-bit RGB and sync out
`timescale 1ns/10ps
`default_nettype none

module video (
	input  logic                  clk,
	input  logic                  arst_n,
	input  video_pkg::color_idx_t color,
	input  video_pkg::vpos_t      count_v,
	input  logic                  palette,
	input  logic                  scanlines,
	input  logic                  overscan,
	input  logic                  sck,
	input  logic                  ss,
	input  logic                  sdi,
	output logic [5:0]            vga_r,
	output logic [5:0]            vga_g,
	output logic [5:0]            vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  osd_visible
);
	logic picture, os_flag, odd_line, hs, vs;
	video_pkg::hpos_t hpos;
	video_pkg::vpos_t vpos;
	video_pkg::rgb15_t word;
	video_pkg::rgb18_t shaded;

	video_timing u_timing (
		.clk, .arst_n, .count_v,
		.picture, .overscan(os_flag), .odd_line,
		.hs, .vs, .hpos, .vpos
	);

	nes_palette u_palette (.clk, .arst_n, .color, .palette, .word);

	pixel_shader u_shader (
		.clk, .arst_n, .word, .picture, .overscan(os_flag), .odd_line,
		.scanlines, .overscan_en(overscan), .pixel(shaded)
	);

	osd_overlay u_osd (
		.clk, .arst_n, .sck, .ss, .sdi,
		.pixel_in(shaded), .hpos, .vpos, .hs_in(hs), .vs_in(vs),
		.pixel_out({vga_r, vga_g, vga_b}), .hs_n(vga_hs), .vs_n(vga_vs), .osd_visible
	);

endmodule

`default_nettype wire

//--- video_chk.sv
// assertions on sync width, OSD enable timing and blanking, bound to video
`timescale 1ns/10ps
`default_nettype none
`include "video_consts.svh"

module video_chk (
	input logic       clk,
	input logic       arst_n,
	input logic       ss,
	input logic [5:0] vga_r,
	input logic [5:0] vga_g,
	input logic [5:0] vga_b,
	input logic       vga_hs,
	input logic       vga_vs,
	input logic       osd_visible
);
	int hs_len; // length of the current hs pulse
	int fail_cnt = 0; // failed assertions so far

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			hs_len <= 0;
		else
			hs_len <= vga_hs ? 0 : hs_len + 1;
	end

	hs_width: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(vga_hs) |-> hs_len == (`HS_END - `HS_START))
		else begin
			$error("hs pulse has wrong width");
			fail_cnt++;
		end

	// ss reaches the receiver through a two-flop synchronizer
	osd_change: assert property (@(posedge clk) disable iff (!arst_n)
		$changed(osd_visible) |-> !$past(ss, 3))
		else begin
			$error("osd_visible changed outside a transfer");
			fail_cnt++;
		end

	vs_black: assert property (@(posedge clk) disable iff (!arst_n)
		!vga_vs |-> (vga_r == 6'd0) && (vga_g == 6'd0) && (vga_b == 6'd0))
		else begin
			$error("pixel not black during vs");
			fail_cnt++;
		end

endmodule

bind video video_chk chk0 (.*);

`default_nettype wire

//--- tb_video.sv
// testbench for the video output stage, table of probes checked against
// a reference built from the palette files and the shading rules
`timescale 1ns/10ps
`default_nettype none
`include "video_consts.svh"

module tb_video;
	typedef struct {
		string name;
		bit    pal;
		bit    scan;
		bit    os;
		int    cmd; // 0 none, 1 enable, 2 disable
		int    ph;
		int    pv;
	} row_t;

	logic clk = 1'b0;
	logic arst_n, palette, scanlines, overscan, sck, ss, sdi;
	video_pkg::color_idx_t color = '0;
	video_pkg::vpos_t count_v = '0;
	logic [5:0] vga_r, vga_g, vga_b;
	logic vga_hs, vga_vs, osd_visible;
	video_pkg::hpos_t src_h, nh;
	video_pkg::vpos_t src_v, nv;
	logic [15:0] fceux_ref [0:63];
	logic [15:0] unsat_ref [0:63];
	logic [7:0] bitmap_model [0:127];
	bit osd_model;
	integer seed = 32'hb11d_6c12;
	row_t rows [12];

	video dut0 (.*);

	always #2 clk = !clk;

	function automatic logic [5:0] pixel_index(input int h, input int v);
		return 6'((h + 3 * v) % 64);
	endfunction

	// source model, same raster totals as the DUT
	assign nh = (src_h == 340) ? 9'd0 : src_h + 9'd1;
	assign nv = (src_h != 340) ? src_v : ((src_v == 261) ? 9'd0 : src_v + 9'd1);

	always @(posedge clk) begin
		if (!arst_n) begin
			src_h <= '0;
			src_v <= '0;
			color <= '0;
			count_v <= '0;
		end else begin
			src_h <= nh;
			src_v <= nv;
			color <= pixel_index(int'(nh), int'(nv));
			count_v <= nv;
		end
	end

	// the locked counters trail the source by one cycle,
	// so the index seen at (h,v) is the source's (h+1,v)
	function automatic video_pkg::rgb18_t expected_pixel(input bit pal, input bit scan,
			input bit os, input int h, input int v);
		logic [15:0] w;
		logic [4:0] ch [3];
		logic [5:0] c6 [3];
		video_pkg::rgb18_t p;
		bit pic, bord, inwin;
		int wx, wy;
		w = pal ? unsat_ref[pixel_index(h + 1, v)] : fceux_ref[pixel_index(h + 1, v)];
		ch[0] = w[4:0];
		ch[1] = w[9:5];
		ch[2] = w[14:10];
		pic = (h < `H_ACTIVE) && (v < `V_ACTIVE);
		bord = (h < `OS_LEFT) || (h >= `OS_RIGHT) || (v < `OS_TOP) || (v > `OS_BOTTOM);
		wx = h - `OSD_X;
		wy = v - `OSD_Y;
		inwin = (wx >= 0) && (wx < `OSD_W) && (wy >= 0) && (wy < `OSD_H);
		for (int i = 0; i < 3; i++) begin
			if (!pic)
				c6[i] = 6'd0;
			else if (os && bord)
				c6[i] = {4'd0, ch[i][4], 1'b0};
			else if (scan && v[0])
				c6[i] = {1'b0, ch[i][4:1], 1'b0};
			else
				c6[i] = {ch[i], 1'b0};
			if (osd_model && inwin) begin
				if (bitmap_model[7'(wy * 8 + wx / 8)][3'(7 - wx % 8)])
					c6[i] = 6'h3f;
				else
					c6[i] = c6[i] >> 1;
			end
		end
		p.r = c6[0];
		p.g = c6[1];
		p.b = c6[2];
		return p;
	endfunction

	task automatic check_rgb(input string name, input video_pkg::rgb18_t exp,
			input video_pkg::rgb18_t act);
		if (exp !== act) begin
			$display("ERR %s rgb expected %h actual %h", name, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic wait_position(input string what, input int h, input int v);
		int n;
		n = 0;
		@(negedge clk);
		while (!(int'(src_h) == h && int'(src_v) == v)) begin
			if (n > 200000) begin
				$display("timeout waiting for %s", what);
				$display("Test failed");
				$fatal(1);
			end
			n++;
			@(negedge clk);
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			@(posedge clk);
			sdi <= b[i];
			sck <= 1'b0;
			repeat (4) @(posedge clk);
			sck <= 1'b1; // sampled on this rise
			repeat (3) @(posedge clk);
		end
	endtask

	task automatic start_transfer();
		@(posedge clk);
		ss <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic end_transfer();
		repeat (8) @(posedge clk);
		ss <= 1'b1;
		repeat (8) @(posedge clk);
	endtask

	task automatic load_bitmap();
		int r;
		start_transfer();
		send_byte(`CMD_WRITE);
		for (int i = 0; i < 128; i++) begin
			r = $random(seed);
			bitmap_model[i] = r[7:0];
			send_byte(r[7:0]);
		end
		end_transfer();
	endtask

	initial begin
		arst_n = 1'b0;
		palette = 1'b0;
		scanlines = 1'b0;
		overscan = 1'b0;
		sck = 1'b0;
		ss = 1'b1;
		sdi = 1'b0;
		osd_model = 1'b0;
		$readmemh("nes_palette_fceux.txt", fceux_ref);
		$readmemh("nes_palette_unsat.txt", unsat_ref);
		rows[0] = '{"pal0_active", 0, 0, 0, 0, 50, 22};
		rows[1] = '{"pal1_active", 1, 0, 0, 0, 130, 101};
		rows[2] = '{"blank_hsync", 0, 0, 0, 0, 290, 50};
		rows[3] = '{"blank_vsync", 0, 0, 0, 0, 40, 246};
		rows[4] = '{"os_left_on", 0, 0, 1, 0, 4, 100};
		rows[5] = '{"os_left_off", 0, 0, 0, 0, 4, 100};
		rows[6] = '{"os_bottom_on", 1, 0, 1, 0, 120, 235};
		rows[7] = '{"scan_odd", 0, 1, 0, 0, 60, 33};
		rows[8] = '{"scan_even", 0, 1, 0, 0, 60, 34};
		rows[9] = '{"osd_enabled", 0, 0, 0, 1, 100, 113};
		rows[10] = '{"osd_pal1", 1, 0, 0, 0, 150, 121};
		rows[11] = '{"osd_disabled", 0, 0, 0, 2, 100, 113};
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		load_bitmap();
		foreach (rows[i]) begin
			@(posedge clk);
			palette <= rows[i].pal;
			scanlines <= rows[i].scan;
			overscan <= rows[i].os;
			if (rows[i].cmd != 0) begin
				start_transfer();
				send_byte((rows[i].cmd == 1) ? `CMD_ENABLE : `CMD_DISABLE);
				end_transfer();
				osd_model = (rows[i].cmd == 1);
			end
			wait_position("frame start", 0, 0);
			wait_position("probe position", rows[i].ph + 1, rows[i].pv);
			repeat (3) @(posedge clk);
			@(negedge clk);
			check_rgb(rows[i].name, expected_pixel(rows[i].pal, rows[i].scan, rows[i].os,
				rows[i].ph, rows[i].pv), {vga_r, vga_g, vga_b});
			check_bit({rows[i].name, " hs"},
				!((rows[i].ph >= `HS_START) && (rows[i].ph < `HS_END)), vga_hs);
			check_bit({rows[i].name, " vs"},
				!((rows[i].pv >= `VS_START) && (rows[i].pv < `VS_END)), vga_vs);
			check_bit({rows[i].name, " osd_visible"}, osd_model, osd_visible);
		end
		if (dut0.chk0.fail_cnt != 0) begin
			$display("bound assertions failed %0d times", dut0.chk0.fail_cnt);
			$display("Test failed");
			$fatal(1);
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- nes_palette_fceux.txt
// one RGB555 word per line, index 0 first; bits 14:10 blue, 9:5 green, 4:0 red
39ce
4c00
5000
4804
3409
0c0c
000b
0017
0142
00c0
0100
0080
2d00
0000
0000
0000
5ef7
7d80
7884
7c0e
5817
1c1a
005b
00df
0281
0280
0200
2240
5a00
0000
0000
0000
7fff
7eee
7e13
7def
7d9f
4a5f
1edf
02bf
019f
2b7b
33bf
7f2a
7f60
318c
0000
0000
7fff
7f7b
7f78
7ef8
7ed9
6f7e
631f
573f
4b3f
4fbe
5fbe
7f9f
7fe0
6318
0000
0000

//--- nes_palette_unsat.txt
// one RGB555 word per line, index 0 first; bits 14:10 blue, 9:5 green, 4:0 red
35ad
4843
4c44
4447
3469
1869
0869
04d1
0541
0583
05c3
11c2
2dc0
0000
0000
0000
5294
6d0a
6cd0
6491
5094
3095
1497
0d9d
0dda
0aa5
0ae6
1ae4
3a64
0421
0000
0000
7fff
7e53
7ddb
7d9f
7d5e
5d7f
3dbf
2e3f
2edf
2b5a
2f9a
3f99
5f78
2108
0000
0000
7fff
7f39
7f1c
7efe
7ebf
6e9f
6ebf
635f
5f9f
5fbd
63fd
6ffc
7bfb
56b5
0000
0000

//--- tb.f
+incdir+.
video_pkg.sv
video_timing.sv
nes_palette.sv
pixel_shader.sv
osd_overlay.sv
video.sv
video_chk.sv
tb_video.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_video -o tb_video
	obj_dir/tb_video | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
